// ==== bench/uart_hub_chk.sv ====
`timescale 1ns/10ps

module uart_hub_chk (
   input logic                                clk,
   input logic                                rst_n,
   input logic                                cmd_req,
   input logic                                cmd_ack,
   input logic [uart_hub_pkg::lane_count-1:0] load,
   input logic [uart_hub_pkg::lane_count-1:0] busy,
   input logic [uart_hub_pkg::lane_count-1:0] tx,
   input logic                                rd_req,
   input logic                                rd_ack,
   input uart_hub_pkg::lane_id_t              rd_lane,
   input uart_hub_pkg::byte_t                 rd_data,
   input logic                                rd_err,
   input logic                                rd_ovr
);

   a_ack_on_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(cmd_ack) |-> cmd_req) else $error("cmd_ack rose without cmd_req");

   a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      rd_req && !rd_ack |=> rd_req) else $error("rd_req dropped before rd_ack");

   a_payload: assert property (@(posedge clk) disable iff (!rst_n)
      rd_req |=> !rd_req || $stable({rd_lane, rd_data, rd_err, rd_ovr}))
      else $error("read payload moved while rd_req was high");

   // strobe lasts one cycle and starts an idle lane
   a_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
      |load |=> (load == '0) && ((busy & $past(load)) == $past(load)))
      else $error("load strobe did not start an idle lane");

   a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n)
      (tx | busy) == '1) else $error("tx low on an idle lane");   // line rests at 1

endmodule

// ==== bench/uart_hub_tb.sv ====
`timescale 1ns/10ps

module uart_hub_tb;

   logic                                clk = 1'b0;
   logic                                rst_n = 1'b0;
   logic                                cmd_req = 1'b0;
   uart_hub_pkg::lane_id_t              cmd_lane = '0;
   uart_hub_pkg::cmd_t                  cmd_data = '0;
   logic                                cmd_ack;
   logic [uart_hub_pkg::lane_count-1:0] rx;
   logic [uart_hub_pkg::lane_count-1:0] tx;
   logic                                rd_req;
   uart_hub_pkg::lane_id_t              rd_lane;
   uart_hub_pkg::byte_t                 rd_data;
   logic                                rd_err;
   logic                                rd_ovr;
   logic                                rd_ack = 1'b0;
   logic                                inj_en = 1'b0;
   logic                                inj_bit = 1'b1;
   uart_hub_pkg::lane_id_t              inj_lane = '0;
   logic [31:0]                         lfsr = 32'h84884c44;
   logic [11:0]                         exp_q[$];   // lane, ovr, err, data
   logic [uart_hub_pkg::lane_count-1:0] owed [uart_hub_pkg::lane_count] = '{default: '0};
   int                                  ack_delay = 0;
   int                                  errors = 0;
   int                                  checks = 0;
   int                                  mark = 0;

   uart_hub dut (.*);

   bind uart_hub uart_hub_chk chk (
      .clk(clk), .rst_n(rst_n), .cmd_req(cmd_req), .cmd_ack(cmd_ack), .load(load),
      .busy(busy), .tx(tx), .rd_req(rd_req), .rd_ack(rd_ack), .rd_lane(rd_lane),
      .rd_data(rd_data), .rd_err(rd_err), .rd_ovr(rd_ovr)
   );

   always #20 clk = ~clk;

   // loopback unless a lane is being fed by the serializer
   always_comb begin
      rx = tx;
      if (inj_en)
         rx[inj_lane] = inj_bit;
   end

   // ============================================================
   // models
   // ============================================================
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [1:0][7:0] ref_bytes(input uart_hub_pkg::cmd_t c);
      return {c[15:8], c[7:0]};   // [1] goes out first
   endfunction

   function automatic logic [10:0] frame_of(input logic [7:0] d, input logic bad_par,
                                            input logic bad_stop);
      int ones = 0;
      for (int i = 0; i < 8; i++)
         if (d[i])
            ones++;
      return {1'b0, d, (ones % 2 == 0) ^ bad_par, ~bad_stop};
   endfunction

   function automatic logic [21:0] line_image(input uart_hub_pkg::cmd_t c);
      return {frame_of(c[15:8], 1'b0, 1'b0), frame_of(c[7:0], 1'b0, 1'b0)};
   endfunction

   task automatic note_fail(input string what);
      errors++;
      $display("failure at %0t: %s", $time, what);
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic report(input int n, input string what);
      $display("test %0d %s: %0d errors", n, what, errors - mark);
      mark = errors;
   endtask

   // ============================================================
   // host side
   // ============================================================
   task automatic send_cmd(input uart_hub_pkg::lane_id_t lane, input uart_hub_pkg::cmd_t c);
      @(posedge clk);
      #2;
      cmd_req = 1'b1;
      cmd_lane = lane;
      cmd_data = c;
      for (int t = 0; t < 100 && !cmd_ack; t++)
         @(negedge clk);
      if (!cmd_ack)
         note_fail("cmd_ack never rose");
      @(posedge clk);
      #2;
      cmd_req = 1'b0;
      for (int t = 0; t < 20 && cmd_ack; t++)
         @(negedge clk);
      if (cmd_ack)
         note_fail("cmd_ack stayed high after cmd_req fell");
   endtask

   task automatic expect_cmd(input uart_hub_pkg::lane_id_t lane, input uart_hub_pkg::cmd_t c);
      logic [1:0][7:0] b;
      b = ref_bytes(c);
      exp_q.push_back({lane, 2'b00, b[1]});
      exp_q.push_back({lane, 2'b00, b[0]});
   endtask

   // start bit shows two cycles after the request edge
   task automatic capture_tx(input uart_hub_pkg::lane_id_t lane, output logic [21:0] img);
      repeat (3) @(posedge clk);
      for (int i = 21; i >= 0; i--) begin
         @(negedge clk);
         img[i] = tx[lane];
      end
   endtask

   task automatic inject(input uart_hub_pkg::lane_id_t lane, input logic [10:0] fr);
      inj_lane = lane;
      for (int i = 10; i >= 0; i--) begin
         @(posedge clk);
         #2;
         inj_en = 1'b1;
         inj_bit = fr[i];
      end
      @(posedge clk);
      #2;
      inj_bit = 1'b1;
      repeat (4) @(posedge clk);
      #2;
      inj_en = 1'b0;
   endtask

   task automatic host_read(output logic [11:0] got, output logic [3:0] held);
      got = {rd_lane, rd_ovr, rd_err, rd_data};
      held = dut.has_byte;
      repeat (ack_delay) @(posedge clk);
      @(posedge clk);
      #2;
      rd_ack = 1'b1;
      for (int t = 0; t < 20 && rd_req; t++)
         @(negedge clk);
      if (rd_req)
         note_fail("rd_req stayed high after rd_ack");
      @(posedge clk);
      #2;
      rd_ack = 1'b0;
   endtask

   task automatic drain(input int limit);
      for (int t = 0; t < limit && exp_q.size() != 0; t++)
         @(negedge clk);
      if (exp_q.size() != 0)
         note_fail($sformatf("%0d expected bytes were never read", exp_q.size()));
      exp_q.delete();
   endtask

   always @(negedge clk) begin : compare
      logic [11:0] got;
      logic [3:0]  held;
      int          idx;
      if (rd_req) begin
         host_read(got, held);
         idx = -1;
         foreach (exp_q[i])
            if (idx < 0 && exp_q[i][11:10] == got[11:10])
               idx = i;
         if (idx < 0) begin
            note_fail($sformatf("read from lane %0d with no byte expected", got[11:10]));
         end else begin
            check_val("rd_data", 32'(got[7:0]), 32'(exp_q[idx][7:0]));
            check_val("rd_err", 32'(got[8]), 32'(exp_q[idx][8]));
            check_val("rd_ovr", 32'(got[9]), 32'(exp_q[idx][9]));
            exp_q.delete(idx);
         end
         // lanes holding a byte now must be served before this lane again
         if (owed[got[11:10]] != '0)
            note_fail($sformatf("lane %0d served twice while another held a byte", got[11:10]));
         foreach (owed[k])
            owed[k][got[11:10]] = 1'b0;
         owed[got[11:10]] = held;
         owed[got[11:10]][got[11:10]] = 1'b0;
      end
   end

   // ============================================================
   // tests
   // ============================================================
   initial begin : main
      uart_hub_pkg::cmd_t     c;
      uart_hub_pkg::cmd_t     c2;
      uart_hub_pkg::lane_id_t lane;
      logic [21:0]            img;
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;

      check_val("cmd_ack", 32'(cmd_ack), 32'h0);
      check_val("rd_req", 32'(rd_req), 32'h0);
      check_val("tx", 32'(tx), 32'hf);
      report(1, "reset state");

      c = 16'(rand_bits(16));
      expect_cmd(2'd2, c);
      fork
         send_cmd(2'd2, c);
         capture_tx(2'd2, img);
      join
      check_val("tx image", 32'(img), 32'(line_image(c)));
      drain(200);
      report(2, "tx line image");

      for (int n = 0; n < 12; n++) begin
         lane = 2'(rand_bits(2));
         c = 16'(rand_bits(16));
         ack_delay = int'(rand_bits(2));
         expect_cmd(lane, c);
         send_cmd(lane, c);
         drain(200);
      end
      report(3, "random loopback");

      ack_delay = 0;
      c = 16'(rand_bits(16));
      exp_q.push_back({2'd1, 2'b01, c[15:8]});
      inject(2'd1, frame_of(c[15:8], 1'b1, 1'b0));   // even parity
      drain(100);
      exp_q.push_back({2'd1, 2'b01, c[7:0]});
      inject(2'd1, frame_of(c[7:0], 1'b0, 1'b1));    // stop bit 0
      drain(100);
      report(4, "frame errors");

      lane = 2'(rand_bits(2));
      c = 16'(rand_bits(16));
      c2 = 16'(rand_bits(16));
      ack_delay = 60;   // host stalls past both commands
      exp_q.push_back({lane, 2'b00, c[15:8]});
      exp_q.push_back({lane, 2'b10, c[7:0]});
      send_cmd(lane, c);
      send_cmd(lane, c2);
      drain(400);
      ack_delay = 0;
      report(5, "overrun");

      for (int k = 0; k < 4; k++) begin
         c = 16'(rand_bits(16));
         expect_cmd(2'(k), c);
         send_cmd(2'(k), c);
      end
      drain(300);
      report(6, "all lanes");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   initial begin : watchdog
      #1000000;
      $display("timeout: the run did not finish in time");
      $display("Test failed");
      $finish;
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps --top-module uart_hub_tb \
   -f vlog.f -o uart_hub_sim > build.log 2>&1 &&
./obj_dir/uart_hub_sim > sim.log 2>&1 ||
echo "build or simulation ended with an error"
grep -q "Test completed successfully" sim.log && { echo PASS; exit 0; } || { echo FAIL; exit 1; }

// ==== source/cmd_dispatch.sv ====
`timescale 1ns/10ps

module cmd_dispatch (
   input  logic                                   clk,
   input  logic                                   rst_n,
   input  logic                                   cmd_req,
   input  uart_hub_pkg::lane_id_t                 cmd_lane,
   input  uart_hub_pkg::cmd_t                     cmd_data,
   input  logic [uart_hub_pkg::lane_count-1:0]    busy,
   output logic                                   cmd_ack,
   output logic [uart_hub_pkg::lane_count-1:0]    load,
   output uart_hub_pkg::cmd_t                     load_data
);

   uart_hub_pkg::disp_state_t state;
   uart_hub_pkg::lane_id_t    lane_q;
   uart_hub_pkg::cmd_t        data_q;
   logic                      lane_free;

   assign lane_free = ~busy[lane_q];
   assign load_data = data_q;
   assign cmd_ack   = (state == uart_hub_pkg::d_release);

   // one-cycle strobe, only toward an idle lane
   always_comb begin
      load = '0;
      if (state == uart_hub_pkg::d_load && lane_free)
         load[lane_q] = 1'b1;
   end

   // ============================================================
   // host handshake
   // ============================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= uart_hub_pkg::d_idle;
      end else begin
         case (state)
            uart_hub_pkg::d_idle: begin
               if (cmd_req)
                  state <= uart_hub_pkg::d_load;
            end
            uart_hub_pkg::d_load: begin
               if (lane_free)
                  state <= uart_hub_pkg::d_release;   // ack on this edge
            end
            uart_hub_pkg::d_release: begin
               if (!cmd_req)
                  state <= uart_hub_pkg::d_idle;
            end
            default: state <= uart_hub_pkg::d_idle;
         endcase
      end
   end

   // command and lane captured on the way into d_load
   always_ff @(posedge clk) begin
      if (state == uart_hub_pkg::d_idle && cmd_req) begin
         lane_q <= cmd_lane;
         data_q <= cmd_data;
      end
   end

endmodule

// ==== source/read_arbiter.sv ====
`timescale 1ns/10ps

module read_arbiter (
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   input  logic [uart_hub_pkg::lane_count-1:0]                  has_byte,
   input  uart_hub_pkg::byte_t [uart_hub_pkg::lane_count-1:0]   held_data,
   input  logic [uart_hub_pkg::lane_count-1:0]                  held_err,
   input  logic [uart_hub_pkg::lane_count-1:0]                  held_ovr,
   input  logic                                                 rd_ack,
   output logic [uart_hub_pkg::lane_count-1:0]                  take,
   output logic                                                 rd_req,
   output uart_hub_pkg::lane_id_t                               rd_lane,
   output uart_hub_pkg::byte_t                                  rd_data,
   output logic                                                 rd_err,
   output logic                                                 rd_ovr
);

   uart_hub_pkg::rd_state_t state;
   uart_hub_pkg::lane_id_t  ptr;        // lane looked at this cycle
   uart_hub_pkg::lane_id_t  ptr_next;
   logic                    hit;

   assign hit      = (state == uart_hub_pkg::r_scan) && has_byte[ptr];
   assign rd_req   = (state == uart_hub_pkg::r_offer);
   assign ptr_next = (ptr == uart_hub_pkg::lane_id_t'(uart_hub_pkg::lane_count - 1)) ?
                     '0 : ptr + 1'b1;

   always_comb begin
      take = '0;
      if (hit)
         take[ptr] = 1'b1;
   end

   // ============================================================
   // scan and host read handshake
   // ============================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= uart_hub_pkg::r_scan;
         ptr   <= '0;
      end else begin
         case (state)
            uart_hub_pkg::r_scan: begin
               ptr <= ptr_next;   // served lane goes to the back
               if (hit)
                  state <= uart_hub_pkg::r_offer;
            end
            uart_hub_pkg::r_offer: begin
               if (rd_ack)
                  state <= uart_hub_pkg::r_release;
            end
            uart_hub_pkg::r_release: begin
               if (!rd_ack)
                  state <= uart_hub_pkg::r_scan;
            end
            default: state <= uart_hub_pkg::r_scan;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (hit) begin
         rd_lane <= ptr;
         rd_data <= held_data[ptr];
         rd_err  <= held_err[ptr];
         rd_ovr  <= held_ovr[ptr];
      end
   end

endmodule

// ==== source/uart_hub.sv ====
`timescale 1ns/10ps

module uart_hub (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                cmd_req,
   input  uart_hub_pkg::lane_id_t              cmd_lane,
   input  uart_hub_pkg::cmd_t                  cmd_data,
   output logic                                cmd_ack,
   input  logic [uart_hub_pkg::lane_count-1:0] rx,
   output logic [uart_hub_pkg::lane_count-1:0] tx,
   output logic                                rd_req,
   output uart_hub_pkg::lane_id_t              rd_lane,
   output uart_hub_pkg::byte_t                 rd_data,
   output logic                                rd_err,
   output logic                                rd_ovr,
   input  logic                                rd_ack
);

   logic [uart_hub_pkg::lane_count-1:0]                load;
   logic [uart_hub_pkg::lane_count-1:0]                busy;
   uart_hub_pkg::cmd_t                                 load_data;
   logic [uart_hub_pkg::lane_count-1:0]                has_byte;
   uart_hub_pkg::byte_t [uart_hub_pkg::lane_count-1:0] held_data;
   logic [uart_hub_pkg::lane_count-1:0]                held_err;
   logic [uart_hub_pkg::lane_count-1:0]                held_ovr;
   logic [uart_hub_pkg::lane_count-1:0]                take;

   cmd_dispatch u_dispatch (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd_req   (cmd_req),
      .cmd_lane  (cmd_lane),
      .cmd_data  (cmd_data),
      .busy      (busy),
      .cmd_ack   (cmd_ack),
      .load      (load),
      .load_data (load_data)
   );

   for (genvar i = 0; i < uart_hub_pkg::lane_count; i++) begin : g_lane
      uart_lane u_lane (
         .clk       (clk),
         .rst_n     (rst_n),
         .load      (load[i]),
         .load_data (load_data),
         .rx        (rx[i]),
         .take      (take[i]),
         .busy      (busy[i]),
         .tx        (tx[i]),
         .has_byte  (has_byte[i]),
         .held_data (held_data[i]),
         .held_err  (held_err[i]),
         .held_ovr  (held_ovr[i])
      );
   end

   read_arbiter u_reader (
      .clk       (clk),
      .rst_n     (rst_n),
      .has_byte  (has_byte),
      .held_data (held_data),
      .held_err  (held_err),
      .held_ovr  (held_ovr),
      .rd_ack    (rd_ack),
      .take      (take),
      .rd_req    (rd_req),
      .rd_lane   (rd_lane),
      .rd_data   (rd_data),
      .rd_err    (rd_err),
      .rd_ovr    (rd_ovr)
   );

endmodule

// ==== source/uart_hub_pkg.sv ====
package uart_hub_pkg;

   // ============================================================
   // sizes
   // ============================================================
   localparam int lane_count = 4;
   localparam int frame_bits = 11;   // start + 8 data + parity + stop

   typedef logic [1:0]  lane_id_t;
   typedef logic [15:0] cmd_t;
   typedef logic [7:0]  byte_t;
   typedef logic [10:0] frame_t;      // shift image, start bit on top

   // ============================================================
   // state machines
   // ============================================================
   typedef enum logic {
      rx_idle,
      rx_shift
   } rx_state_t;

   typedef enum logic [1:0] {
      d_idle,
      d_load,      // waiting for the target lane to go idle
      d_release
   } disp_state_t;

   typedef enum logic [1:0] {
      r_scan,
      r_offer,     // rd_req high, payload frozen
      r_release
   } rd_state_t;

endpackage

// ==== source/uart_lane.sv ====
`timescale 1ns/10ps

module uart_lane (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                load,
   input  uart_hub_pkg::cmd_t  load_data,
   input  logic                rx,
   input  logic                take,
   output logic                busy,
   output logic                tx,
   output logic                has_byte,
   output uart_hub_pkg::byte_t held_data,
   output logic                held_err,
   output logic                held_ovr
);

   // start, data msb first, odd parity, stop
   function automatic uart_hub_pkg::frame_t make_frame(input uart_hub_pkg::byte_t d);
      return {1'b0, d, ~^d, 1'b1};
   endfunction

   logic [2*uart_hub_pkg::frame_bits-1:0] tx_image;
   logic [2*uart_hub_pkg::frame_bits-1:0] tx_sr;
   logic [4:0]                            tx_cnt;   // bits still to show

   uart_hub_pkg::rx_state_t                rx_state;
   logic [1:0]                             rx_sync;
   logic                                   rx_s;
   logic [3:0]                             rx_cnt;
   logic [uart_hub_pkg::frame_bits-3:0]    rx_sr;    // data bits then parity
   logic [uart_hub_pkg::frame_bits-2:0]    rx_word;
   logic                                   frame_done;
   logic                                   frame_err;

   // ============================================================
   // transmitter
   // ============================================================
   assign tx_image = {make_frame(load_data[15:8]), make_frame(load_data[7:0])};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy   <= 1'b0;
         tx     <= 1'b1;
         tx_cnt <= '0;
      end else if (load) begin
         busy   <= 1'b1;
         tx     <= tx_image[2*uart_hub_pkg::frame_bits-1];   // start bit out now
         tx_cnt <= 5'(2*uart_hub_pkg::frame_bits - 1);
      end else if (busy) begin
         if (tx_cnt == '0) begin
            busy <= 1'b0;
            tx   <= 1'b1;
         end else begin
            tx     <= tx_sr[2*uart_hub_pkg::frame_bits-1];
            tx_cnt <= tx_cnt - 5'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load)
         tx_sr <= {tx_image[2*uart_hub_pkg::frame_bits-2:0], 1'b1};
      else if (busy)
         tx_sr <= {tx_sr[2*uart_hub_pkg::frame_bits-2:0], 1'b1};
   end

   // ============================================================
   // receiver
   // ============================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         rx_sync <= 2'b11;   // line idles high
      else
         rx_sync <= {rx_sync[0], rx};
   end

   assign rx_s       = rx_sync[1];
   assign frame_done = (rx_state == uart_hub_pkg::rx_shift) &&
                       (rx_cnt == 4'(uart_hub_pkg::frame_bits - 2));
   assign rx_word    = {rx_sr, rx_s};                       // stop bit in lsb
   assign frame_err  = ~(^rx_word[uart_hub_pkg::frame_bits-2:1]) | ~rx_word[0];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_state <= uart_hub_pkg::rx_idle;
         rx_cnt   <= '0;
      end else begin
         case (rx_state)
            uart_hub_pkg::rx_idle: begin
               rx_cnt <= '0;
               if (!rx_s)
                  rx_state <= uart_hub_pkg::rx_shift;
            end
            uart_hub_pkg::rx_shift: begin
               rx_cnt <= rx_cnt + 4'd1;
               if (frame_done)
                  rx_state <= uart_hub_pkg::rx_idle;   // back to back frames ok
            end
            default: rx_state <= uart_hub_pkg::rx_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rx_state == uart_hub_pkg::rx_shift)
         rx_sr <= {rx_sr[uart_hub_pkg::frame_bits-4:0], rx_s};
   end

   // one-entry holding register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         has_byte <= 1'b0;
         held_ovr <= 1'b0;
      end else begin
         if (frame_done && (!has_byte || take))
            has_byte <= 1'b1;
         else if (take)
            has_byte <= 1'b0;

         if (frame_done && has_byte && !take)
            held_ovr <= 1'b1;   // new byte dropped
         else if (take)
            held_ovr <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (frame_done && (!has_byte || take)) begin
         held_data <= rx_word[uart_hub_pkg::frame_bits-2:2];
         held_err  <= frame_err;
      end
   end

endmodule

// ==== vlog.f ====
source/uart_hub_pkg.sv
source/cmd_dispatch.sv
source/uart_lane.sv
source/read_arbiter.sv
source/uart_hub.sv
bench/uart_hub_chk.sv
bench/uart_hub_tb.sv
